//--- Bender.yml
package:
  name: sdram_controller

sources:
  - files:
      - verilog/sdram_pkg.sv
      - verilog/sdram_cmd_if.sv
      - verilog/sdram_request_queue.sv
      - verilog/sdram_refresh_timer.sv
      - verilog/sdram_bank_tracker.sv
      - verilog/sdram_sequencer.sv
      - verilog/sdram_io_regs.sv
      - verilog/sdram_controller.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/sdram_model.sv
      - bench/tb_sdram_controller.sv

//--- all.f
verilog/sdram_pkg.sv
verilog/sdram_cmd_if.sv
verilog/sdram_request_queue.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_bank_tracker.sv
verilog/sdram_sequencer.sv
verilog/sdram_io_regs.sv
verilog/sdram_controller.sv
bench/tb_clock_gen.sv
bench/sdram_model.sv
bench/tb_sdram_controller.sv

//--- bench/sdram_model.sv
`timescale 1ns/1ps

module sdram_model #(
  parameter int CAS_LATENCY = 2
) (
  input  logic                 sys_clk,
  input  logic                 cke,
  input  logic                 cs_n,
  input  logic                 ras_n,
  input  logic                 cas_n,
  input  logic                 we_n,
  input  sdram_pkg::bank_t     ba,
  input  sdram_pkg::pin_addr_t addr,
  inout  wire sdram_pkg::data_t dq,
  output int                   act_count,
  output int                   ref_count,
  output int                   wr_count,
  output int                   pre_single_count,  // Precharges of one bank only
  output int                   bad_count,         // Illegal command sequences seen
  output int                   log_count,
  output logic [15:0]          log_cmds,          // First four commands, oldest low
  output logic                 first_a10,
  output sdram_pkg::pin_addr_t mode_value
);
  import sdram_pkg::*;

  sdram_cmd_t             cmd;
  logic [3:0]             open_q;
  row_addr_t              row_q [4];
  data_t                  mem [host_addr_t];
  logic [CAS_LATENCY-1:0] rd_pipe;                // Read data in flight
  data_t                  rd_word [CAS_LATENCY];
  host_addr_t             key;
  logic                   is_read;

  assign cmd     = {cs_n, ras_n, cas_n, we_n};
  assign key     = {row_q[ba], ba, addr[COL_W-1:0]};
  assign is_read = cke && (cmd == CMD_READ) && open_q[ba];
  assign dq      = rd_pipe[CAS_LATENCY-1] ? rd_word[CAS_LATENCY-1] : 'z;

  initial begin
    act_count        = 0;
    ref_count        = 0;
    wr_count         = 0;
    pre_single_count = 0;
    bad_count        = 0;
    log_count        = 0;
    log_cmds         = '0;
    first_a10        = 1'b0;
    mode_value       = '0;
    open_q           = '0;
    rd_pipe          = '0;
  end

  always @(posedge sys_clk) begin
    rd_pipe    <= {rd_pipe[CAS_LATENCY-2:0], is_read};
    rd_word[0] <= mem.exists(key) ? mem[key] : 'x;
    for (int i = 1; i < CAS_LATENCY; i++) rd_word[i] <= rd_word[i-1];
    if (cke && cmd != CMD_NOP && log_count < 4) begin
      log_cmds[log_count*4 +: 4] <= cmd;     // Power-up order
      if (log_count == 0) first_a10 <= addr[PRECHARGE_ALL_BIT];
      log_count <= log_count + 1;
    end
    if (cke) begin
      case (cmd)
        CMD_ACTIVE: begin
          if (open_q[ba]) bad_count <= bad_count + 1;  // Row already open
          open_q[ba] <= 1'b1;
          row_q[ba]  <= addr;
          act_count  <= act_count + 1;
        end
        CMD_READ: if (!open_q[ba]) bad_count <= bad_count + 1;
        CMD_WRITE: begin
          if (!open_q[ba]) bad_count <= bad_count + 1;
          else mem[key] = dq;
          wr_count <= wr_count + 1;
        end
        CMD_PRECHARGE: begin
          if (addr[PRECHARGE_ALL_BIT]) begin
            open_q <= '0;
          end else begin
            open_q[ba]       <= 1'b0;
            pre_single_count <= pre_single_count + 1;
          end
        end
        CMD_REFRESH: begin
          if (|open_q) bad_count <= bad_count + 1;    // Needs all banks idle
          ref_count <= ref_count + 1;
        end
        CMD_LOAD_MODE: mode_value <= addr;
        default: ;
      endcase
    end
  end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter realtime PERIOD_NS    = 40.0,
  parameter int      RESET_CYCLES = 2
) (
  output logic sys_clk,
  output logic sys_reset
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) sys_clk = ~sys_clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    sys_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    sys_reset <= 1'b0;
  end

endmodule

//--- bench/tb_sdram_controller.sv
`timescale 1ns/1ps

module tb_sdram_controller;
  import sdram_pkg::*;

  localparam int INIT_DELAY       = 200;
  localparam int REFRESH_INTERVAL = 400;
  localparam int OP_WR = 0, OP_RD = 1, OP_WR_DUP = 2, OP_WAIT_REF = 3;

  typedef struct {
    int         op;
    host_addr_t addr;
    data_t      data;     // Write word, or expected read word
    int         exp_act;  // Activates when no refresh came between
  } row_t;

  logic sys_clk, sys_reset, rw, in_valid, cke, cs_n, ras_n, cas_n, we_n;
  logic sys_data_from_sdram_valid, busy, first_a10;
  host_addr_t sys_addr;
  data_t      sys_data_to_sdram, sys_data_from_sdram;
  bank_t      ba;
  pin_addr_t  addr, mode_value;
  wire data_t dq;
  int act_count, ref_count, wr_count, pre_single_count, bad_count, log_count;
  logic [15:0] log_cmds;
  row_t  tbl [$];
  data_t shadow [host_addr_t];
  logic [15:0] lfsr;
  int cycle_count, valid_count, reads_sent, ref_seen, gap;
  int limit;

  tb_clock_gen clock_gen_inst (.sys_clk, .sys_reset);

  sdram_controller #(.INIT_DELAY(INIT_DELAY), .REFRESH_INTERVAL(REFRESH_INTERVAL))
    sdram_controller_inst (
    .sys_clk, .sys_reset, .sys_addr, .sys_data_to_sdram, .rw, .in_valid,
    .sys_data_from_sdram, .sys_data_from_sdram_valid, .busy, .sdram_cke(cke),
    .sdram_cs_n(cs_n), .sdram_ras_n(ras_n), .sdram_cas_n(cas_n), .sdram_we_n(we_n),
    .sdram_ba(ba), .sdram_addr(addr), .sdram_dq(dq)
  );

  sdram_model #(.CAS_LATENCY(2)) sdram_model_inst (
    .sys_clk, .cke, .cs_n, .ras_n, .cas_n, .we_n, .ba, .addr, .dq, .act_count,
    .ref_count, .wr_count, .pre_single_count, .bad_count, .log_count, .log_cmds,
    .first_a10, .mode_value
  );

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois taps 16,14,13,11
  endfunction

  function automatic data_t random_word();
    data_t w;
    for (int i = 0; i < DATA_W; i++) begin
      lfsr = lfsr_step(lfsr);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  // Expected read data comes from the shadow of earlier writes
  function automatic void add_row(int op, row_addr_t r, bank_t b, col_addr_t c, int act);
    row_t t;
    t.op = op;
    t.addr = {r, b, c};
    t.exp_act = act;
    if (op == OP_WR || op == OP_WR_DUP) begin
      t.data = random_word();
      shadow[t.addr] = t.data;
    end else begin
      t.data = (op == OP_RD) ? shadow[t.addr] : '0;
    end
    tbl.push_back(t);
  endfunction

  task automatic send(logic wr, host_addr_t a, data_t d, bit dup);
    @(posedge sys_clk);
    while (busy) @(posedge sys_clk);
    in_valid          <= 1'b1;
    rw                <= wr;
    sys_addr          <= a;
    sys_data_to_sdram <= d;
    @(posedge sys_clk);                       // Taken here
    if (dup) begin
      sys_data_to_sdram <= ~d;                // Second pulse lands on busy
      @(posedge sys_clk);
    end
    in_valid <= 1'b0;
  endtask

  // Hang guard sized from init, table length and refresh spacing
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Regression failed");
      $fatal(1);
    end
  end

  always @(posedge sys_clk) begin
    if (sys_data_from_sdram_valid) valid_count <= valid_count + 1;
    // Load mode may still sit on the pins in the first cycle without busy
    if (!sys_reset && !busy && log_count != 4) begin
      check_value("log_count", log_count, 3);
      check_value("sdram_cmd", {cs_n, ras_n, cas_n, we_n}, CMD_LOAD_MODE);
    end
    if (log_count == 4) begin       // Refresh spacing after load mode
      if (ref_count != ref_seen) gap <= 0;
      else gap <= gap + 1;
      ref_seen <= ref_count;
      check_value("refresh_gap_ok", gap <= REFRESH_INTERVAL + 60, 1);
    end
  end

  initial begin
    row_t  t;
    int    act0, pre0, wr0, last_ref, exp_pre;
    bit    refreshed;
    bit    open_bank [4];
    row_addr_t open_row [4];
    bank_t b;
    row_addr_t r;
    in_valid          = 1'b0;
    rw                = 1'b0;
    sys_addr          = '0;
    sys_data_to_sdram = '0;
    lfsr              = 16'd18;
    cycle_count       = 0;
    valid_count       = 0;
    reads_sent        = 0;
    ref_seen          = 0;
    gap               = 0;
    add_row(OP_WR, 5, 0, 3, 1);
    add_row(OP_RD, 5, 0, 3, 0);
    add_row(OP_WR, 5, 0, 9, 0);
    add_row(OP_WR, 7, 0, 3, 1);     // Row change in bank 0
    add_row(OP_RD, 5, 0, 3, 1);
    add_row(OP_WR, 2, 1, 4, 1);
    add_row(OP_WR_DUP, 2, 1, 5, 0);
    add_row(OP_RD, 2, 1, 5, 0);
    add_row(OP_RD, 5, 0, 9, 0);
    add_row(OP_WAIT_REF, 0, 0, 0, 0);
    add_row(OP_RD, 2, 1, 4, 1);     // Rows closed by refresh
    add_row(OP_RD, 7, 0, 3, 1);
    limit = INIT_DELAY + 60 * tbl.size() + 2 * REFRESH_INTERVAL;

    @(posedge sys_clk);
    while (sys_reset || busy) @(posedge sys_clk);
    @(posedge sys_clk);             // Model logs load mode one edge after the pins
    check_value("init_cmd_0", log_cmds[3:0], CMD_PRECHARGE);
    check_value("init_a10", first_a10, 1);
    check_value("init_cmd_1", log_cmds[7:4], CMD_REFRESH);
    check_value("init_cmd_2", log_cmds[11:8], CMD_REFRESH);
    check_value("init_cmd_3", log_cmds[15:12], CMD_LOAD_MODE);
    check_value("mode_value", mode_value, MODE_REG_VALUE);
    check_value("mode_value_cas_latency", mode_value[6:4], 2);
    check_value("mode_value_burst_type", mode_value[3], 0);
    check_value("mode_value_burst_length", mode_value[2:0], 0);  // Code 0 is one word

    last_ref = ref_count;
    foreach (open_bank[i]) open_bank[i] = 0;
    for (int i = 0; i < tbl.size(); i++) begin
      t    = tbl[i];
      act0 = act_count;
      pre0 = pre_single_count;
      wr0  = wr_count;
      b = t.addr[COL_W +: BANK_W];
      r = t.addr[COL_W+BANK_W +: ROW_W];
      if (t.op == OP_WAIT_REF) begin
        while (ref_count == last_ref) @(posedge sys_clk);
      end else if (t.op == OP_RD) begin
        send(1'b0, t.addr, '0, 0);
        reads_sent++;
        while (!sys_data_from_sdram_valid) @(posedge sys_clk);
        check_value("sys_data_from_sdram", sys_data_from_sdram, t.data);
        @(posedge sys_clk);
        check_value("sys_data_from_sdram_valid", sys_data_from_sdram_valid, 0);
      end else begin
        send(1'b1, t.addr, t.data, t.op == OP_WR_DUP);
        while (wr_count == wr0) @(posedge sys_clk);
        if (t.op == OP_WR_DUP) begin
          repeat (20) @(posedge sys_clk);   // Room for a stray second write
          check_value("write_count", wr_count - wr0, 1);
        end
      end
      refreshed = (ref_count != last_ref);
      last_ref = ref_count;
      if (refreshed) foreach (open_bank[j]) open_bank[j] = 0;
      if (t.op != OP_WAIT_REF) begin
        exp_pre = open_bank[b] && (open_row[b] != r);
        check_value("activate_delta", act_count - act0,
                    (refreshed || !open_bank[b]) ? 1 : t.exp_act);
        check_value("single_precharge_delta", pre_single_count - pre0, exp_pre);
        open_bank[b] = 1;
        open_row[b] = r;
      end
      check_value("protocol_errors", bad_count, 0);
    end
    check_value("valid_pulses", valid_count, reads_sent);
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog/sdram_bank_tracker.sv
`timescale 1ns/1ps

module sdram_bank_tracker (
  input  logic                  sys_clk,
  input  logic                  sys_reset,
  input  sdram_pkg::bank_t      lookup_bank,
  input  sdram_pkg::row_addr_t  lookup_row,
  input  logic                  mark_active,     // ACTIVE issued on update_bank
  input  logic                  mark_precharge,  // PRECHARGE issued
  input  logic                  precharge_all,   // With A10 high
  input  sdram_pkg::bank_t      update_bank,
  input  sdram_pkg::row_addr_t  update_row,
  output logic                  bank_open,
  output logic                  row_hit
);
  import sdram_pkg::*;

  logic [3:0] open_q;       // One flag per bank
  row_addr_t  row_q [4];    // Row held open in each bank

  // Lookup for the pending request
  assign bank_open = open_q[lookup_bank];
  assign row_hit   = bank_open && (row_q[lookup_bank] == lookup_row);

  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      open_q <= '0;
    end else if (mark_active) begin
      open_q[update_bank] <= 1'b1;
    end else if (mark_precharge) begin
      if (precharge_all) open_q <= '0;
      else open_q[update_bank] <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (mark_active) row_q[update_bank] <= update_row;
  end

endmodule

//--- verilog/sdram_cmd_if.sv
`timescale 1ns/1ps

interface sdram_cmd_if;
  import sdram_pkg::*;

  sdram_cmd_t cmd;    // Command for the next pin cycle
  bank_t      ba;
  pin_addr_t  addr;
  data_t      wdata;  // Write word, goes out with dq_en
  logic       dq_en;  // Drive DQ in the next pin cycle
  data_t      rdata;  // DQ as sampled by the pad flops

  modport sequencer (
    output cmd, ba, addr, wdata, dq_en,
    input  rdata
  );

  modport phy (
    input  cmd, ba, addr, wdata, dq_en,
    output rdata
  );

endinterface

//--- verilog/sdram_controller.sv
`timescale 1ns/1ps

module sdram_controller #(
  parameter int INIT_DELAY       = 10100,  // Power-up wait in cycles
  parameter int REFRESH_INTERVAL = 1530
) (
  input  logic                  sys_clk,
  input  logic                  sys_reset,
  input  sdram_pkg::host_addr_t sys_addr,
  input  sdram_pkg::data_t      sys_data_to_sdram,
  input  logic                  rw,
  input  logic                  in_valid,
  output sdram_pkg::data_t      sys_data_from_sdram,
  output logic                  sys_data_from_sdram_valid,
  output logic                  busy,
  output logic                  sdram_cke,
  output logic                  sdram_cs_n,
  output logic                  sdram_ras_n,
  output logic                  sdram_cas_n,
  output logic                  sdram_we_n,
  output sdram_pkg::bank_t      sdram_ba,
  output sdram_pkg::pin_addr_t  sdram_addr,
  inout  wire sdram_pkg::data_t sdram_dq
);
  import sdram_pkg::*;

  logic       init_done, req_take, req_pending, req_rw;
  host_addr_t req_addr;
  data_t      req_data;
  logic       refresh_due, refresh_ack, timer_start;
  bank_t      lookup_bank, update_bank;
  row_addr_t  lookup_row, update_row;
  logic       bank_open, row_hit;
  logic       mark_active, mark_precharge, precharge_all;

  sdram_cmd_if cmd_bus ();  // Sequencer to pad flops

  sdram_request_queue sdram_request_queue_inst (
    .sys_clk, .sys_reset, .in_valid, .rw, .sys_addr, .sys_data_to_sdram,
    .init_done, .req_take, .busy, .req_pending, .req_rw, .req_addr, .req_data
  );

  sdram_refresh_timer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) sdram_refresh_timer_inst (
    .sys_clk, .sys_reset, .timer_start, .refresh_ack, .refresh_due
  );

  sdram_bank_tracker sdram_bank_tracker_inst (
    .sys_clk, .sys_reset, .lookup_bank, .lookup_row, .mark_active, .mark_precharge,
    .precharge_all, .update_bank, .update_row, .bank_open, .row_hit
  );

  sdram_sequencer #(.INIT_DELAY(INIT_DELAY)) sdram_sequencer_inst (
    .sys_clk, .sys_reset, .req_pending, .req_rw, .req_addr, .req_data, .req_take,
    .refresh_due, .refresh_ack, .timer_start, .lookup_bank, .lookup_row,
    .bank_open, .row_hit, .mark_active, .mark_precharge, .precharge_all,
    .update_bank, .update_row, .cmd(cmd_bus),
    .rd_data(sys_data_from_sdram), .rd_valid(sys_data_from_sdram_valid), .init_done
  );

  sdram_io_regs sdram_io_regs_inst (
    .sys_clk, .sys_reset, .cmd(cmd_bus), .sdram_cke, .sdram_cs_n, .sdram_ras_n,
    .sdram_cas_n, .sdram_we_n, .sdram_ba, .sdram_addr, .sdram_dq
  );

endmodule

//--- verilog/sdram_io_regs.sv
`timescale 1ns/1ps

module sdram_io_regs (
  input  logic                 sys_clk,
  input  logic                 sys_reset,
  sdram_cmd_if.phy             cmd,
  output logic                 sdram_cke,
  output logic                 sdram_cs_n,
  output logic                 sdram_ras_n,
  output logic                 sdram_cas_n,
  output logic                 sdram_we_n,
  output sdram_pkg::bank_t     sdram_ba,
  output sdram_pkg::pin_addr_t sdram_addr,
  inout  wire sdram_pkg::data_t sdram_dq
);
  import sdram_pkg::*;

  sdram_cmd_t cmd_q;
  logic       dq_en_q;
  data_t      wdata_q;
  data_t      rdata_q;

  assign {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_q;
  assign sdram_dq  = dq_en_q ? wdata_q : 'z;  // Released unless writing
  assign cmd.rdata = rdata_q;

  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      sdram_cke <= 1'b0;
      cmd_q     <= CMD_NOP;
      dq_en_q   <= 1'b0;
    end else begin
      sdram_cke <= 1'b1;    // Clock enable comes up after reset
      cmd_q     <= cmd.cmd;
      dq_en_q   <= cmd.dq_en;
    end
  end

  // Address, write data and read capture in the pad flops
  always_ff @(posedge sys_clk) begin
    sdram_ba   <= cmd.ba;
    sdram_addr <= cmd.addr;
    wdata_q    <= cmd.wdata;
    rdata_q    <= sdram_dq;
  end

endmodule

//--- verilog/sdram_pkg.sv
package sdram_pkg;

  // Field widths of the 16-bit, four-bank part
  localparam int ROW_W       = 12;
  localparam int BANK_W      = 2;
  localparam int COL_W       = 8;
  localparam int DATA_W      = 16;
  localparam int HOST_ADDR_W = ROW_W + BANK_W + COL_W;  // Row, bank, column from the top

  typedef logic [HOST_ADDR_W-1:0] host_addr_t;
  typedef logic [ROW_W-1:0]       row_addr_t;
  typedef logic [BANK_W-1:0]      bank_t;
  typedef logic [COL_W-1:0]       col_addr_t;
  typedef logic [DATA_W-1:0]      data_t;
  typedef logic [3:0]             sdram_cmd_t;  // {cs_n, ras_n, cas_n, we_n}
  typedef logic [ROW_W-1:0]       pin_addr_t;
  typedef logic [15:0]            delay_cnt_t;

  // Command truth table, all strobes active low
  localparam sdram_cmd_t CMD_NOP       = 4'b0111;
  localparam sdram_cmd_t CMD_ACTIVE    = 4'b0011;
  localparam sdram_cmd_t CMD_READ      = 4'b0101;
  localparam sdram_cmd_t CMD_WRITE     = 4'b0100;
  localparam sdram_cmd_t CMD_PRECHARGE = 4'b0010;
  localparam sdram_cmd_t CMD_REFRESH   = 4'b0001;
  localparam sdram_cmd_t CMD_LOAD_MODE = 4'b0000;

  // Programmed burst, standard op, CL2, sequential, BL1
  localparam pin_addr_t MODE_REG_VALUE = {2'b00, 1'b0, 2'b00, 3'b010, 1'b0, 3'b000};

  localparam int PRECHARGE_ALL_BIT = 10;  // A10 high closes every bank

  // WAIT counts, the WAIT entry cycle adds one more
  localparam delay_cnt_t T_RP_CYCLES     = 16'd1;
  localparam delay_cnt_t T_RFC_CYCLES    = 16'd6;
  localparam delay_cnt_t T_MRD_CYCLES    = 16'd1;
  localparam delay_cnt_t CAS_WAIT_CYCLES = 16'd2;

  typedef enum logic [3:0] {
    ST_INIT, ST_WAIT, ST_PRECHARGE_INIT, ST_REFRESH_INIT_1, ST_REFRESH_INIT_2,
    ST_LOAD_MODE, ST_IDLE, ST_REFRESH, ST_ACTIVATE, ST_READ, ST_READ_RES,
    ST_WRITE, ST_PRECHARGE
  } seq_state_t;

endpackage

//--- verilog/sdram_refresh_timer.sv
`timescale 1ns/1ps

module sdram_refresh_timer #(
  parameter int REFRESH_INTERVAL = 1530
) (
  input  logic sys_clk,
  input  logic sys_reset,
  input  logic timer_start,  // End of init, restart the interval
  input  logic refresh_ack,
  output logic refresh_due
);
  localparam int CNT_W = $clog2(REFRESH_INTERVAL + 1);

  logic [CNT_W-1:0] count_q;
  logic             running_q;  // Counting only after init
  logic             wrap;

  assign wrap = running_q && (count_q == CNT_W'(REFRESH_INTERVAL - 1));

  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      count_q     <= '0;
      running_q   <= 1'b0;
      refresh_due <= 1'b0;
    end else if (timer_start) begin
      count_q     <= '0;
      running_q   <= 1'b1;
      refresh_due <= 1'b0;
    end else begin
      if (wrap) count_q <= '0;
      else if (running_q) count_q <= count_q + 1'b1;
      // Sticky until the sequencer takes it, a new interval wins
      if (wrap) refresh_due <= 1'b1;
      else if (refresh_ack) refresh_due <= 1'b0;
    end
  end

endmodule

//--- verilog/sdram_request_queue.sv
`timescale 1ns/1ps

module sdram_request_queue (
  input  logic                 sys_clk,
  input  logic                 sys_reset,
  input  logic                 in_valid,
  input  logic                 rw,                 // 1 selects write
  input  sdram_pkg::host_addr_t sys_addr,
  input  sdram_pkg::data_t     sys_data_to_sdram,
  input  logic                 init_done,
  input  logic                 req_take,           // Sequencer empties the slot
  output logic                 busy,
  output logic                 req_pending,
  output logic                 req_rw,
  output sdram_pkg::host_addr_t req_addr,
  output sdram_pkg::data_t     req_data
);
  import sdram_pkg::*;

  logic accept;

  assign accept = in_valid && !busy;  // Requests during busy are dropped
  assign busy   = !init_done || req_pending;

  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      req_pending <= 1'b0;
    end else if (accept) begin
      req_pending <= 1'b1;
    end else if (req_take) begin
      req_pending <= 1'b0;
    end
  end

  // Request payload, only loaded on acceptance
  always_ff @(posedge sys_clk) begin
    if (accept) begin
      req_rw   <= rw;
      req_addr <= sys_addr;
      req_data <= sys_data_to_sdram;
    end
  end

endmodule

//--- verilog/sdram_sequencer.sv
`timescale 1ns/1ps

module sdram_sequencer #(
  parameter int INIT_DELAY = 10100
) (
  input  logic                  sys_clk,
  input  logic                  sys_reset,
  input  logic                  req_pending,
  input  logic                  req_rw,
  input  sdram_pkg::host_addr_t req_addr,
  input  sdram_pkg::data_t      req_data,
  output logic                  req_take,
  input  logic                  refresh_due,
  output logic                  refresh_ack,
  output logic                  timer_start,
  output sdram_pkg::bank_t      lookup_bank,
  output sdram_pkg::row_addr_t  lookup_row,
  input  logic                  bank_open,
  input  logic                  row_hit,
  output logic                  mark_active,
  output logic                  mark_precharge,
  output logic                  precharge_all,
  output sdram_pkg::bank_t      update_bank,
  output sdram_pkg::row_addr_t  update_row,
  sdram_cmd_if.sequencer        cmd,
  output sdram_pkg::data_t      rd_data,
  output logic                  rd_valid,
  output logic                  init_done
);
  import sdram_pkg::*;

  seq_state_t state_q, state_d;
  seq_state_t return_q, return_d;  // Where WAIT goes when the count runs out
  delay_cnt_t delay_q, delay_d;
  host_addr_t op_addr_q, op_addr_d;  // Request under execution
  logic       op_rw_q, op_rw_d;
  data_t      op_data_q, op_data_d;
  logic       pre_all_q, pre_all_d;
  bank_t      pre_bank_q, pre_bank_d;
  data_t      rd_data_d;
  logic       rd_valid_d;
  logic       init_done_d;
  bank_t      op_bank;
  row_addr_t  op_row;
  col_addr_t  op_col;

  assign op_col  = op_addr_q[COL_W-1:0];
  assign op_bank = op_addr_q[COL_W +: BANK_W];
  assign op_row  = op_addr_q[COL_W+BANK_W +: ROW_W];

  // Tracker always looks at the queued request
  assign lookup_bank = req_addr[COL_W +: BANK_W];
  assign lookup_row  = req_addr[COL_W+BANK_W +: ROW_W];

  always_comb begin
    state_d        = state_q;
    return_d       = return_q;
    delay_d        = delay_q;
    op_addr_d      = op_addr_q;
    op_rw_d        = op_rw_q;
    op_data_d      = op_data_q;
    pre_all_d      = pre_all_q;
    pre_bank_d     = pre_bank_q;
    rd_data_d      = rd_data;
    rd_valid_d     = 1'b0;   // Single-cycle pulse
    init_done_d    = init_done;
    cmd.cmd        = CMD_NOP;
    cmd.ba         = '0;
    cmd.addr       = '0;
    cmd.wdata      = op_data_q;
    cmd.dq_en      = 1'b0;   // Bus stays high-Z by default
    req_take       = 1'b0;
    refresh_ack    = 1'b0;
    timer_start    = 1'b0;
    mark_active    = 1'b0;
    mark_precharge = 1'b0;
    precharge_all  = 1'b0;
    update_bank    = op_bank;
    update_row     = op_row;

    case (state_q)
      ST_INIT: begin
        state_d  = ST_WAIT;
        delay_d  = delay_cnt_t'(INIT_DELAY);  // Power-up wait
        return_d = ST_PRECHARGE_INIT;
      end
      ST_WAIT: begin
        delay_d = delay_q - 1'b1;
        if (delay_q == '0) begin
          state_d = return_q;
          if (return_q == ST_WRITE) cmd.dq_en = 1'b1;  // Drive data a cycle ahead
        end
      end
      ST_PRECHARGE_INIT: begin
        cmd.cmd                     = CMD_PRECHARGE;
        cmd.addr[PRECHARGE_ALL_BIT] = 1'b1;  // All banks
        state_d                     = ST_WAIT;
        delay_d                     = T_RP_CYCLES;
        return_d                    = ST_REFRESH_INIT_1;
      end
      ST_REFRESH_INIT_1, ST_REFRESH_INIT_2: begin
        cmd.cmd  = CMD_REFRESH;
        state_d  = ST_WAIT;
        delay_d  = T_RFC_CYCLES;
        return_d = (state_q == ST_REFRESH_INIT_1) ? ST_REFRESH_INIT_2 : ST_LOAD_MODE;
      end
      ST_LOAD_MODE: begin
        cmd.cmd     = CMD_LOAD_MODE;
        cmd.addr    = MODE_REG_VALUE;
        state_d     = ST_WAIT;
        delay_d     = T_MRD_CYCLES;
        return_d    = ST_IDLE;
        timer_start = 1'b1;   // Refresh interval starts here
        init_done_d = 1'b1;   // Queue opens next cycle
      end
      ST_IDLE: begin
        if (refresh_due) begin
          // Refresh beats a waiting request
          refresh_ack = 1'b1;
          pre_all_d   = 1'b1;
          pre_bank_d  = '0;
          state_d     = ST_PRECHARGE;
          return_d    = ST_REFRESH;
        end else if (req_pending) begin
          req_take  = 1'b1;
          op_addr_d = req_addr;
          op_rw_d   = req_rw;
          op_data_d = req_data;
          if (row_hit) begin
            state_d = req_rw ? ST_WRITE : ST_READ;   // Row already open
          end else if (bank_open) begin
            pre_all_d  = 1'b0;          // Close only this bank
            pre_bank_d = lookup_bank;
            state_d    = ST_PRECHARGE;
            return_d   = ST_ACTIVATE;
          end else begin
            state_d = ST_ACTIVATE;
          end
        end
      end
      ST_REFRESH: begin
        cmd.cmd  = CMD_REFRESH;
        state_d  = ST_WAIT;
        delay_d  = T_RFC_CYCLES;
        return_d = ST_IDLE;
      end
      ST_ACTIVATE: begin
        cmd.cmd     = CMD_ACTIVE;
        cmd.ba      = op_bank;
        cmd.addr    = op_row;
        mark_active = 1'b1;
        state_d     = ST_WAIT;
        delay_d     = '0;       // One spare cycle covers tRCD
        return_d    = op_rw_q ? ST_WRITE : ST_READ;
      end
      ST_READ: begin
        cmd.cmd  = CMD_READ;
        cmd.ba   = op_bank;
        cmd.addr = pin_addr_t'(op_col);
        state_d  = ST_WAIT;
        delay_d  = CAS_WAIT_CYCLES;  // CL2 plus the pad flops
        return_d = ST_READ_RES;
      end
      ST_READ_RES: begin
        rd_data_d  = cmd.rdata;
        rd_valid_d = 1'b1;
        state_d    = ST_IDLE;
      end
      ST_WRITE: begin
        cmd.cmd   = CMD_WRITE;
        cmd.ba    = op_bank;
        cmd.addr  = pin_addr_t'(op_col);
        cmd.dq_en = 1'b1;
        state_d   = ST_IDLE;     // Nothing reported back
      end
      ST_PRECHARGE: begin
        cmd.cmd                     = CMD_PRECHARGE;
        cmd.ba                      = pre_bank_q;
        cmd.addr[PRECHARGE_ALL_BIT] = pre_all_q;
        mark_precharge              = 1'b1;
        precharge_all               = pre_all_q;
        update_bank                 = pre_bank_q;
        state_d                     = ST_WAIT;
        delay_d                     = T_RP_CYCLES;
      end
      default: state_d = ST_INIT;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (sys_reset) begin
      state_q   <= ST_INIT;
      return_q  <= ST_INIT;
      delay_q   <= '0;
      rd_valid  <= 1'b0;
      init_done <= 1'b0;
    end else begin
      state_q   <= state_d;
      return_q  <= return_d;
      delay_q   <= delay_d;
      rd_valid  <= rd_valid_d;
      init_done <= init_done_d;
    end
  end

  // Operation payload
  always_ff @(posedge sys_clk) begin
    op_addr_q  <= op_addr_d;
    op_rw_q    <= op_rw_d;
    op_data_q  <= op_data_d;
    pre_all_q  <= pre_all_d;
    pre_bank_q <= pre_bank_d;
    rd_data    <= rd_data_d;
  end

endmodule
